// File: ooo_pkg.sv
// shared widths and tag counts for the out-of-order response station
// packed structs for response beats, buffer entries, get replies and egress
`default_nettype none

package ooo_pkg;

    // tag 0 is reserved and never handed out
    localparam int TAG_NUM     = 16;
    localparam int TAG_W       = $clog2(TAG_NUM);
    localparam int QUEUE_NUM   = 4;
    localparam int QUEUE_W     = $clog2(QUEUE_NUM);
    localparam int RESP_DATA_W = 16;
    localparam int SLOT_DATA_W = 32;

    // tagged response from the resource
    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [RESP_DATA_W-1:0] data;
    } resp_beat_t;

    // one reorder buffer entry
    typedef struct packed {
        logic                   valid;
        logic [RESP_DATA_W-1:0] data;
    } rob_entry_t;

    // write into the reorder buffer
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        rob_entry_t       entry;
    } rob_wr_t;

    // queue head reply from the reservation station
    typedef struct packed {
        logic             empty;
        logic [TAG_W-1:0] tag;
    } get_resp_t;

    // one released beat
    typedef struct packed {
        logic [QUEUE_W-1:0]     queue;
        logic [RESP_DATA_W-1:0] resp_data;
        logic [SLOT_DATA_W-1:0] slot_data;
    } egress_t;

endpackage

`default_nettype wire

// File: tag_pool.sv
// free-tag FIFO, filled by a sweep after reset and refilled by released tags
// tag-to-queue table written on allocation
`timescale 1ns/1ps
`default_nettype none

module tag_pool import ooo_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    output logic               alloc_valid,
    output logic [TAG_W-1:0]   alloc_tag,
    input  logic [QUEUE_W-1:0] alloc_queue,
    input  logic               alloc_ready,
    input  logic [TAG_W-1:0]   map_tag,
    output logic [QUEUE_W-1:0] map_queue,
    input  logic               free_valid,
    input  logic [TAG_W-1:0]   free_tag
);

    logic [TAG_W-1:0]   fifo_mem [TAG_NUM];
    logic [QUEUE_W-1:0] map_table [TAG_NUM];
    logic [TAG_W-1:0]   wr_ptr;
    logic [TAG_W-1:0]   rd_ptr;
    logic [TAG_W:0]     fill;
    logic               sweep_active;
    logic [TAG_W-1:0]   sweep_tag;
    logic               push;
    logic               pop;
    logic [TAG_W-1:0]   push_tag;

    // no tag is out during the sweep so no free can collide with it
    assign push     = sweep_active | free_valid;
    assign push_tag = sweep_active ? sweep_tag : free_tag;

    assign alloc_valid = !sweep_active && (fill != '0);
    assign alloc_tag   = fifo_mem[rd_ptr];
    assign pop         = alloc_valid && alloc_ready;

    assign map_queue = map_table[map_tag];

    // sweep tags 1 .. TAG_NUM-1, one per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sweep_active <= 1'b1;
            sweep_tag    <= TAG_W'(1);
        end else if (sweep_active) begin
            if (sweep_tag == TAG_W'(TAG_NUM - 1)) begin
                sweep_active <= 1'b0;
            end
            sweep_tag <= sweep_tag + TAG_W'(1);
        end
    end

    // pointers wrap at the power-of-two depth
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + TAG_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + TAG_W'(1);
            end
            if (push && !pop) begin
                fill <= fill + (TAG_W+1)'(1);
            end else if (pop && !push) begin
                fill <= fill - (TAG_W+1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_tag;
        end
        // bind the tag to its queue in the allocation cycle
        if (pop) begin
            map_table[alloc_tag] <= alloc_queue;
        end
    end

endmodule

`default_nettype wire

// File: resp_capture.sv
// one-entry holding stage for tagged responses
// writes the reorder buffer, then wakes the queue that owns the tag
`timescale 1ns/1ps
`default_nettype none

module resp_capture import ooo_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               resp_valid,
    input  resp_beat_t         resp,
    output logic               resp_ready,
    output logic [TAG_W-1:0]   map_tag,
    input  logic [QUEUE_W-1:0] map_queue,
    output logic               cap_wr_valid,
    output rob_wr_t            cap_wr,
    input  logic               cap_wr_ready,
    output logic               wake_valid,
    output logic [QUEUE_W-1:0] wake_queue,
    input  logic               wake_ready
);

    typedef enum logic [1:0] {
        CAP_EMPTY,
        CAP_WRITE,
        CAP_WAKE
    } cap_phase_e;

    cap_phase_e         phase;
    resp_beat_t         hold_beat;
    logic [QUEUE_W-1:0] hold_queue;

    // table lookup happens in the accept cycle
    assign map_tag    = resp.tag;
    assign resp_ready = (phase == CAP_EMPTY);

    assign cap_wr_valid = (phase == CAP_WRITE);
    assign cap_wr       = '{tag: hold_beat.tag, entry: '{valid: 1'b1, data: hold_beat.data}};

    assign wake_valid = (phase == CAP_WAKE);
    assign wake_queue = hold_queue;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= CAP_EMPTY;
        end else begin
            case (phase)
                CAP_EMPTY: if (resp_valid) phase <= CAP_WRITE;
                CAP_WRITE: if (cap_wr_ready) phase <= CAP_WAKE;
                CAP_WAKE:  if (wake_ready) phase <= CAP_EMPTY;
                default:   phase <= CAP_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid && resp_ready) begin
            hold_beat  <= resp;
            hold_queue <= map_queue;
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
// tag-indexed response store with one combinational read port
// fixed-priority write arbiter, clear requests ahead of captures
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             cap_wr_valid,
    input  rob_wr_t          cap_wr,
    output logic             cap_wr_ready,
    input  logic             clr_wr_valid,
    input  rob_wr_t          clr_wr,
    output logic             clr_wr_ready,
    input  logic [TAG_W-1:0] rob_rd_tag,
    output rob_entry_t       rob_rd
);

    logic [TAG_NUM-1:0]     valid_q;
    logic [RESP_DATA_W-1:0] data_mem [TAG_NUM];

    // grant bit 0 for the clear port and bit 1 for the capture port
    logic [1:0] req;
    logic [1:0] gnt;
    logic       wr_en;
    rob_wr_t    wr;

    assign req = {cap_wr_valid, clr_wr_valid};

    always_comb begin
        gnt = 2'b00;
        if (req[0]) begin
            gnt = 2'b01;
        end else if (req[1]) begin
            gnt = 2'b10;
        end
    end

    // clear always wins and capture waits while a clear is pending
    assign clr_wr_ready = 1'b1;
    assign cap_wr_ready = !req[0];

    assign wr_en = |gnt;
    assign wr    = gnt[0] ? clr_wr : cap_wr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr.tag] <= wr.entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr.tag] <= wr.entry.data;
        end
    end

    assign rob_rd = '{valid: valid_q[rob_rd_tag], data: data_mem[rob_rd_tag]};

endmodule

`default_nettype wire

// File: egress_sequencer.sv
// per-queue release FSM: get head, judge buffer entry, clear, dequeue
// emits one egress beat per released tag and returns the tag to the pool
`timescale 1ns/1ps
`default_nettype none

module egress_sequencer import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wake_valid,
    input  logic [QUEUE_W-1:0]     wake_queue,
    output logic                   wake_ready,
    output logic                   get_req_valid,
    output logic [QUEUE_W-1:0]     get_req_queue,
    input  logic                   get_req_ready,
    input  logic                   get_resp_valid,
    input  get_resp_t              get_resp,
    output logic                   get_resp_ready,
    output logic [TAG_W-1:0]       rob_rd_tag,
    input  rob_entry_t             rob_rd,
    output logic                   deq_req_valid,
    output logic [QUEUE_W-1:0]     deq_req_queue,
    input  logic                   deq_req_ready,
    input  logic                   deq_resp_valid,
    input  logic [SLOT_DATA_W-1:0] deq_resp_data,
    output logic                   deq_resp_ready,
    output logic                   egress_valid,
    output egress_t                egress,
    input  logic                   egress_ready,
    output logic                   clr_wr_valid,
    output rob_wr_t                clr_wr,
    input  logic                   clr_wr_ready,
    output logic                   free_valid,
    output logic [TAG_W-1:0]       free_tag
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_GET_REQ,
        SEQ_GET_RESP,
        SEQ_JUDGE,
        SEQ_CLEAR,
        SEQ_DEQ_REQ,
        SEQ_DEQ_DATA
    } seq_state_e;

    seq_state_e             state;
    seq_state_e             state_d;
    logic [QUEUE_W-1:0]     queue_q;
    logic [TAG_W-1:0]       head_tag;
    logic [RESP_DATA_W-1:0] res_data;
    logic                   egress_done;

    // handshake-level outputs decoded from the state
    assign wake_ready     = (state == SEQ_IDLE);
    assign get_req_valid  = (state == SEQ_GET_REQ);
    assign get_resp_ready = (state == SEQ_GET_RESP);
    assign clr_wr_valid   = (state == SEQ_CLEAR);
    assign deq_req_valid  = (state == SEQ_DEQ_REQ);

    // dequeue reply passes straight through to egress
    assign deq_resp_ready = (state == SEQ_DEQ_DATA) && egress_ready;
    assign egress_valid   = (state == SEQ_DEQ_DATA) && deq_resp_valid;
    assign egress_done    = egress_valid && egress_ready;

    assign get_req_queue = queue_q;
    assign deq_req_queue = queue_q;
    assign rob_rd_tag    = head_tag;

    assign clr_wr = '{tag: head_tag, entry: '{valid: 1'b0, data: '0}};
    assign egress = '{queue: queue_q, resp_data: res_data, slot_data: deq_resp_data};

    // tag goes back to the pool with the beat
    assign free_valid = egress_done;
    assign free_tag   = head_tag;

    always_comb begin
        state_d = state;
        case (state)
            SEQ_IDLE: begin
                if (wake_valid) begin
                    state_d = SEQ_GET_REQ;
                end
            end
            SEQ_GET_REQ: begin
                if (get_req_ready) begin
                    state_d = SEQ_GET_RESP;
                end
            end
            SEQ_GET_RESP: begin
                if (get_resp_valid) begin
                    state_d = get_resp.empty ? SEQ_IDLE : SEQ_JUDGE;
                end
            end
            SEQ_JUDGE: begin
                // head not back yet so its own wake retries the queue
                state_d = rob_rd.valid ? SEQ_CLEAR : SEQ_IDLE;
            end
            SEQ_CLEAR: begin
                if (clr_wr_ready) begin
                    state_d = SEQ_DEQ_REQ;
                end
            end
            SEQ_DEQ_REQ: begin
                if (deq_req_ready) begin
                    state_d = SEQ_DEQ_DATA;
                end
            end
            SEQ_DEQ_DATA: begin
                if (egress_done) begin
                    state_d = SEQ_GET_REQ;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_d;
        end
    end

    // queue, head tag and resource data for the current pass
    always_ff @(posedge clk) begin
        if (wake_valid && wake_ready) begin
            queue_q <= wake_queue;
        end
        if (get_resp_valid && get_resp_ready) begin
            head_tag <= get_resp.tag;
        end
        if (state == SEQ_JUDGE) begin
            res_data <= rob_rd.data;
        end
    end

endmodule

`default_nettype wire

// File: ooo_station.sv
// top level of the out-of-order response station
// tag pool, response capture, reorder buffer and egress sequencer
`timescale 1ns/1ps
`default_nettype none

module ooo_station import ooo_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   alloc_valid,
    output logic [TAG_W-1:0]       alloc_tag,
    input  logic [QUEUE_W-1:0]     alloc_queue,
    input  logic                   alloc_ready,
    input  logic                   resp_valid,
    input  resp_beat_t             resp,
    output logic                   resp_ready,
    output logic                   get_req_valid,
    output logic [QUEUE_W-1:0]     get_req_queue,
    input  logic                   get_req_ready,
    input  logic                   get_resp_valid,
    input  get_resp_t              get_resp,
    output logic                   get_resp_ready,
    output logic                   deq_req_valid,
    output logic [QUEUE_W-1:0]     deq_req_queue,
    input  logic                   deq_req_ready,
    input  logic                   deq_resp_valid,
    input  logic [SLOT_DATA_W-1:0] deq_resp_data,
    output logic                   deq_resp_ready,
    output logic                   egress_valid,
    output egress_t                egress,
    input  logic                   egress_ready
);

    logic [TAG_W-1:0]   map_tag;
    logic [QUEUE_W-1:0] map_queue;
    logic               cap_wr_valid;
    rob_wr_t            cap_wr;
    logic               cap_wr_ready;
    logic               clr_wr_valid;
    rob_wr_t            clr_wr;
    logic               clr_wr_ready;
    logic               wake_valid;
    logic [QUEUE_W-1:0] wake_queue;
    logic               wake_ready;
    logic [TAG_W-1:0]   rob_rd_tag;
    rob_entry_t         rob_rd;
    logic               free_valid;
    logic [TAG_W-1:0]   free_tag;

    tag_pool i_tag_pool (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .alloc_queue (alloc_queue),
        .alloc_ready (alloc_ready),
        .map_tag     (map_tag),
        .map_queue   (map_queue),
        .free_valid  (free_valid),
        .free_tag    (free_tag)
    );

    resp_capture i_resp_capture (
        .clk          (clk),
        .rst          (rst),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .resp_ready   (resp_ready),
        .map_tag      (map_tag),
        .map_queue    (map_queue),
        .cap_wr_valid (cap_wr_valid),
        .cap_wr       (cap_wr),
        .cap_wr_ready (cap_wr_ready),
        .wake_valid   (wake_valid),
        .wake_queue   (wake_queue),
        .wake_ready   (wake_ready)
    );

    reorder_buffer i_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .cap_wr_valid (cap_wr_valid),
        .cap_wr       (cap_wr),
        .cap_wr_ready (cap_wr_ready),
        .clr_wr_valid (clr_wr_valid),
        .clr_wr       (clr_wr),
        .clr_wr_ready (clr_wr_ready),
        .rob_rd_tag   (rob_rd_tag),
        .rob_rd       (rob_rd)
    );

    egress_sequencer i_egress_sequencer (
        .clk            (clk),
        .rst            (rst),
        .wake_valid     (wake_valid),
        .wake_queue     (wake_queue),
        .wake_ready     (wake_ready),
        .get_req_valid  (get_req_valid),
        .get_req_queue  (get_req_queue),
        .get_req_ready  (get_req_ready),
        .get_resp_valid (get_resp_valid),
        .get_resp       (get_resp),
        .get_resp_ready (get_resp_ready),
        .rob_rd_tag     (rob_rd_tag),
        .rob_rd         (rob_rd),
        .deq_req_valid  (deq_req_valid),
        .deq_req_queue  (deq_req_queue),
        .deq_req_ready  (deq_req_ready),
        .deq_resp_valid (deq_resp_valid),
        .deq_resp_data  (deq_resp_data),
        .deq_resp_ready (deq_resp_ready),
        .egress_valid   (egress_valid),
        .egress         (egress),
        .egress_ready   (egress_ready),
        .clr_wr_valid   (clr_wr_valid),
        .clr_wr         (clr_wr),
        .clr_wr_ready   (clr_wr_ready),
        .free_valid     (free_valid),
        .free_tag       (free_tag)
    );

endmodule

`default_nettype wire

// File: tb_ooo_station.sv
// testbench for the out-of-order response station
// reservation station model, egress scoreboard, stimulus and assertions
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_station import ooo_pkg::*; ();

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   alloc_valid;
    logic [TAG_W-1:0]       alloc_tag;
    logic [QUEUE_W-1:0]     alloc_queue;
    logic                   alloc_ready;
    logic                   resp_valid;
    resp_beat_t             resp;
    logic                   resp_ready;
    logic                   get_req_valid;
    logic [QUEUE_W-1:0]     get_req_queue;
    logic                   get_req_ready = 1'b0;
    logic                   get_resp_valid = 1'b0;
    get_resp_t              get_resp = '0;
    logic                   get_resp_ready;
    logic                   deq_req_valid;
    logic [QUEUE_W-1:0]     deq_req_queue;
    logic                   deq_req_ready = 1'b0;
    logic                   deq_resp_valid = 1'b0;
    logic [SLOT_DATA_W-1:0] deq_resp_data = '0;
    logic                   deq_resp_ready;
    logic                   egress_valid;
    egress_t                egress;
    logic                   egress_ready = 1'b1;

    // model lists hold {queue, tag} in allocation order
    logic [QUEUE_W+TAG_W-1:0] rs_list[$];
    logic [QUEUE_W+TAG_W-1:0] exp_list[$];
    logic [RESP_DATA_W-1:0]   sent_data [TAG_NUM];
    logic [TAG_W-1:0]         round_tags [TAG_NUM-1];
    logic [TAG_NUM-1:0]       seen;
    logic                     bp_en = 1'b0;
    logic                     get_pend = 1'b0;
    get_resp_t                get_next = '0;
    logic                     deq_pend = 1'b0;
    logic [SLOT_DATA_W-1:0]   deq_next = '0;
    logic                     hold_pend = 1'b0;
    egress_t                  held_beat = '0;
    int                       beat_count = 0;
    int                       main_errs = 0;
    int                       clocked_errs = 0;
    int                       test_base = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    string                    cur_test = "reset";

    ooo_station i_ooo_station (.*);

    always #50 clk = ~clk;

    function automatic logic [SLOT_DATA_W-1:0] slot_data_for(input logic [TAG_W-1:0] tag);
        return 32'h5100_0000 + SLOT_DATA_W'(tag);
    endfunction

    // index of the oldest entry of a queue or -1 if none
    function automatic int first_of_queue(input logic on_egress, input logic [QUEUE_W-1:0] q);
        int found;
        int i;
        found = -1;
        if (on_egress) begin
            for (i = exp_list.size() - 1; i >= 0; i--) begin
                if (exp_list[i][TAG_W +: QUEUE_W] == q) begin
                    found = i;
                end
            end
        end else begin
            for (i = rs_list.size() - 1; i >= 0; i--) begin
                if (rs_list[i][TAG_W +: QUEUE_W] == q) begin
                    found = i;
                end
            end
        end
        return found;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("CHECK FAILED %s: %s expected %0h, actual %0h", test, what, expected, actual);
    endtask

    // reserved tag 0 is never offered
    assert property (@(posedge clk) disable iff (rst) alloc_valid |-> (alloc_tag != '0))
    else begin
        $display("CHECK FAILED %s: alloc_tag expected nonzero, actual %0d", cur_test, alloc_tag);
        clocked_errs++;
    end

    // reservation station model and egress scoreboard sampled on the edge
    always @(posedge clk) begin : rs_model
        int               idx;
        logic [TAG_W-1:0] tag;
        if (!rst) begin
            if (alloc_valid && alloc_ready) begin
                rs_list.push_back({alloc_queue, alloc_tag});
                exp_list.push_back({alloc_queue, alloc_tag});
            end
            if (get_resp_valid && get_resp_ready) begin
                get_pend = 1'b0;
            end
            if (get_req_valid && get_req_ready) begin
                idx = first_of_queue(1'b0, get_req_queue);
                get_pend = 1'b1;
                get_next.empty = (idx < 0);
                get_next.tag = '0;
                if (idx >= 0) begin
                    get_next.tag = rs_list[idx][TAG_W-1:0];
                end
            end
            if (deq_resp_valid && deq_resp_ready) begin
                deq_pend = 1'b0;
            end
            if (deq_req_valid && deq_req_ready) begin
                idx = first_of_queue(1'b0, deq_req_queue);
                assert (idx >= 0)
                else begin
                    $display("%s: dequeue requested on empty queue %0d", cur_test, deq_req_queue);
                    clocked_errs++;
                end
                if (idx >= 0) begin
                    deq_next = slot_data_for(rs_list[idx][TAG_W-1:0]);
                    rs_list.delete(idx);
                    deq_pend = 1'b1;
                end
            end
            // a stalled beat stays offered unchanged
            if (hold_pend) begin
                assert (egress_valid && (egress == held_beat))
                else begin
                    report_mismatch(cur_test, "stalled egress beat", 64'(held_beat), 64'(egress));
                    clocked_errs++;
                end
            end
            hold_pend = egress_valid && !egress_ready;
            held_beat = egress;
            if (egress_valid && egress_ready) begin
                idx = first_of_queue(1'b1, egress.queue);
                assert (idx >= 0)
                else begin
                    $display("%s: egress beat on queue %0d with nothing outstanding",
                             cur_test, egress.queue);
                    clocked_errs++;
                end
                if (idx >= 0) begin
                    tag = exp_list[idx][TAG_W-1:0];
                    assert (egress.resp_data == sent_data[tag])
                    else begin
                        report_mismatch(cur_test, "egress resp_data",
                                        64'(sent_data[tag]), 64'(egress.resp_data));
                        clocked_errs++;
                    end
                    assert (egress.slot_data == slot_data_for(tag))
                    else begin
                        report_mismatch(cur_test, "egress slot_data",
                                        64'(slot_data_for(tag)), 64'(egress.slot_data));
                        clocked_errs++;
                    end
                    exp_list.delete(idx);
                    beat_count++;
                end
            end
        end
        #1;
        get_resp_valid = get_pend;
        get_resp       = get_next;
        deq_resp_valid = deq_pend;
        deq_resp_data  = deq_next;
        get_req_ready  = ($urandom % 4) != 0;
        deq_req_ready  = ($urandom % 4) != 0;
        egress_ready   = !bp_en || (($urandom % 3) != 0);
    end

    task automatic abort_on_timeout(input string what);
        $display("TIMEOUT in %s: %s", cur_test, what);
        main_errs++;
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = main_errs + clocked_errs;
    endtask

    task automatic end_test();
        int errs;
        errs = main_errs + clocked_errs - test_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", cur_test, errs);
        end
    endtask

    task automatic allocate(input logic [QUEUE_W-1:0] q, output logic [TAG_W-1:0] tag);
        int n;
        alloc_queue = q;
        alloc_ready = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!alloc_valid && n < 100);
        if (!alloc_valid) begin
            abort_on_timeout("no allocation handshake");
        end else begin
            tag = alloc_tag;
            #1;
            alloc_ready = 1'b0;
        end
    endtask

    task automatic check_fresh_tag(input logic [TAG_W-1:0] tag);
        assert (tag != '0 && !seen[tag])
        else begin
            $display("CHECK FAILED %s: expected unused tag in 1..15, actual %0d", cur_test, tag);
            main_errs++;
        end
        seen[tag] = 1'b1;
    endtask

    task automatic send_response(input logic [TAG_W-1:0] tag);
        int n;
        sent_data[tag] = RESP_DATA_W'($urandom);
        resp       = '{tag: tag, data: sent_data[tag]};
        resp_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!resp_ready && n < 500);
        if (!resp_ready) begin
            abort_on_timeout("response not accepted");
        end else begin
            #1;
            resp_valid = 1'b0;
        end
    endtask

    // responses for round_tags[first..] in a random order
    task automatic send_shuffled(input int first);
        int order [TAG_NUM-1];
        int count;
        int i;
        int j;
        int t;
        count = TAG_NUM - 1 - first;
        for (i = 0; i < count; i++) begin
            order[i] = first + i;
        end
        for (i = count - 1; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (i = 0; i < count; i++) begin
            send_response(round_tags[order[i]]);
        end
    endtask

    task automatic wait_for_beats(input int target);
        int n;
        n = 0;
        while (beat_count < target && n < 3000) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (beat_count < target) begin
            abort_on_timeout("egress beats missing");
        end
    endtask

    task automatic wait_alloc_valid(input int limit);
        int n;
        n = 0;
        while (!alloc_valid && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!alloc_valid) begin
            abort_on_timeout("alloc_valid stays low");
        end
    endtask

    initial begin : main
        logic [TAG_W-1:0] tag;
        int               i;
        void'($urandom(32'hc1b7));
        rst         = 1'b1;
        alloc_queue = '0;
        alloc_ready = 1'b0;
        resp_valid  = 1'b0;
        resp        = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("tag sweep");
        wait_alloc_valid(40);
        seen = '0;
        for (i = 0; i < TAG_NUM - 1; i++) begin
            allocate(QUEUE_W'($urandom % QUEUE_NUM), tag);
            round_tags[i] = tag;
            check_fresh_tag(tag);
        end
        // pool is drained so nothing may be offered
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            assert (!alloc_valid)
            else begin
                report_mismatch(cur_test, "alloc_valid when drained", 64'(0), 64'(alloc_valid));
                main_errs++;
            end
        end
        #1;
        end_test();

        begin_test("ordered release");
        send_shuffled(0);
        wait_for_beats(TAG_NUM - 1);
        assert (exp_list.size() == 0)
        else begin
            report_mismatch(cur_test, "outstanding beats", 64'(0), 64'(exp_list.size()));
            main_errs++;
        end
        end_test();

        begin_test("tag recycling");
        wait_alloc_valid(20);
        seen = '0;
        for (i = 0; i < TAG_NUM - 1; i++) begin
            // first two tags share queue 1 for the late head case
            if (i < 2) begin
                allocate(QUEUE_W'(1), tag);
            end else begin
                allocate(QUEUE_W'($urandom % QUEUE_NUM), tag);
            end
            round_tags[i] = tag;
            check_fresh_tag(tag);
        end
        end_test();

        begin_test("late head");
        send_response(round_tags[1]);
        repeat (40) @(posedge clk);
        #1;
        assert (beat_count == TAG_NUM - 1)
        else begin
            report_mismatch(cur_test, "beats before head", 64'(TAG_NUM - 1), 64'(beat_count));
            main_errs++;
        end
        send_response(round_tags[0]);
        wait_for_beats(TAG_NUM + 1);
        end_test();

        begin_test("egress back-pressure");
        bp_en = 1'b1;
        send_shuffled(2);
        wait_for_beats(2 * (TAG_NUM - 1));
        assert (exp_list.size() == 0)
        else begin
            report_mismatch(cur_test, "outstanding beats", 64'(0), 64'(exp_list.size()));
            main_errs++;
        end
        bp_en = 1'b0;
        end_test();

        $display("%0d tests, %0d passed, %0d failed, %0d failed checks", tests_run,
                 tests_run - tests_failed, tests_failed, main_errs + clocked_errs);
        if (main_errs + clocked_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
ooo_pkg.sv
tag_pool.sv
resp_capture.sv
reorder_buffer.sv
egress_sequencer.sv
ooo_station.sv
tb_ooo_station.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ooo_station -f vlog.f -o tb_ooo_station

output=$(./obj_dir/tb_ooo_station)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
